// ==== logic/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// PC loaded on reset
`define FETCH_RESET_PC 32'h0000_0200

// Cache geometry
`define FETCH_LINE_WORDS 4
`define FETCH_LINES 16

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

// Word address split: tag | index | offset
`define FETCH_OFFSET_W ($clog2(`FETCH_LINE_WORDS))
`define FETCH_INDEX_W ($clog2(`FETCH_LINES))
`define FETCH_TAG_W (30 - `FETCH_INDEX_W - `FETCH_OFFSET_W)
`define FETCH_DATA_AW (`FETCH_INDEX_W + `FETCH_OFFSET_W)
`define FETCH_DATA_DEPTH (`FETCH_LINES * `FETCH_LINE_WORDS)

`endif

// ==== logic/fetch_pkg.sv ====
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    // Redirect from later stages; pc_src 01 jump, 10 branch
    typedef struct packed {
        logic [1:0]  pc_src;
        logic [31:0] pc_branch;
        logic [31:0] pc_j;
    } redirect_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    // AXI4-Lite read address channel, master side
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
    } axi_ar_t;

    // AXI4-Lite read data channel, slave side
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_r_t;

    typedef struct packed {
        logic                    valid;
        logic [`FETCH_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [`FETCH_LINE_WORDS-1:0][31:0] line_t;

endpackage

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        load_use_hazard,
    input  redirect_t   redirect,
    input  logic        icache_stall,
    input  logic [31:0] fetch_rdata,
    output logic [29:0] fetch_addr,
    output if_id_t      if_id,
    output logic [31:0] pc
);

    logic [31:0] pc_next;
    logic [31:0] pc_plus4;
    logic [31:0] inst_swapped;
    logic        pc_hold;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (redirect.pc_src)
            2'b01:   pc_next = redirect.pc_j;
            2'b10:   pc_next = redirect.pc_branch;
            default: pc_next = pc_plus4;
        endcase
    end

    // Memory words are little endian
    assign inst_swapped = {fetch_rdata[7:0], fetch_rdata[15:8],
                           fetch_rdata[23:16], fetch_rdata[31:24]};

    assign pc_hold    = stall || load_use_hazard || icache_stall;
    assign fetch_addr = pc[31:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `FETCH_RESET_PC;
        end else if (!pc_hold) begin
            pc <= pc_next;
        end
    end

    // IF/ID loads every cycle, a bubble while flushing or refilling
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else begin
            if_id.pc <= pc;
            if (flush || icache_stall) begin
                if_id.inst <= `FETCH_NOP;
            end else begin
                if_id.inst <= inst_swapped;
            end
        end
    end

    // Redirect targets come from outside, so alignment is checked here
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== logic/icache_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module icache_ram import fetch_pkg::*; #(
    parameter type entry_t = tag_entry_t,
    parameter int  depth   = `FETCH_LINES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [$clog2(depth)-1:0] raddr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [depth];

    // Cleared on reset so every tag starts invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read is combinational for a same-cycle hit
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== logic/refill_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module refill_counter import fetch_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       ar_done,
    input  logic                       r_done,
    output logic [`FETCH_OFFSET_W-1:0] word_offset,
    output logic                       last_beat
);

    logic ar_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_offset <= '0;
        end else if (start) begin
            word_offset <= '0;
        end else if (r_done) begin
            word_offset <= word_offset + 1'b1;
        end
    end

    // Tracks the single outstanding read of this refill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_pending <= 1'b0;
        end else if (start) begin
            ar_pending <= 1'b0;
        end else if (ar_done) begin
            ar_pending <= 1'b1;
        end else if (r_done) begin
            ar_pending <= 1'b0;
        end
    end

    assign last_beat = (word_offset == `FETCH_OFFSET_W'(`FETCH_LINE_WORDS - 1));

    a_r_after_ar: assert property (
        @(posedge clk) disable iff (!rst_n)
        r_done |-> ar_pending
    );

endmodule

`default_nettype wire

// ==== logic/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module icache_ctrl import fetch_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [29:0]                fetch_addr,
    output logic [31:0]                fetch_rdata,
    output logic                       icache_stall,
    input  tag_entry_t                 tag_rdata,
    output logic                       tag_we,
    output tag_entry_t                 tag_wdata,
    input  logic [31:0]                data_rdata,
    output logic                       data_we,
    output logic [`FETCH_DATA_AW-1:0]  data_waddr,
    output logic [31:0]                data_wdata,
    output axi_ar_t                    ar,
    input  logic                       arready,
    input  axi_r_t                     r,
    output logic                       rready,
    output logic                       refill_start,
    output logic                       ar_done,
    output logic                       r_done,
    input  logic [`FETCH_OFFSET_W-1:0] word_offset,
    input  logic                       last_beat
);

    typedef enum logic [1:0] {
        LOOKUP,
        READ_ADDR,
        READ_DATA
    } state_t;

    state_t                    state;
    state_t                    state_next;
    logic [`FETCH_TAG_W-1:0]   fa_tag;
    logic [`FETCH_INDEX_W-1:0] fa_index;
    logic [`FETCH_TAG_W-1:0]   miss_tag;
    logic [`FETCH_INDEX_W-1:0] miss_index;
    logic                      hit;

    assign fa_tag   = fetch_addr[29 -: `FETCH_TAG_W];
    assign fa_index = fetch_addr[`FETCH_OFFSET_W +: `FETCH_INDEX_W];

    assign hit          = tag_rdata.valid && (tag_rdata.tag == fa_tag);
    assign fetch_rdata  = data_rdata;
    assign icache_stall = (state != LOOKUP) || !hit;
    assign refill_start = (state == LOOKUP) && !hit;

    // Line under refill, held so the request ignores fetch_addr
    always_ff @(posedge clk) begin
        if (refill_start) begin
            miss_tag   <= fa_tag;
            miss_index <= fa_index;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (!hit) begin
                    state_next = READ_ADDR;
                end
            end
            READ_ADDR: begin
                if (ar_done) begin
                    state_next = READ_DATA;
                end
            end
            READ_DATA: begin
                if (r_done) begin
                    state_next = last_beat ? LOOKUP : READ_ADDR;
                end
            end
            default: state_next = LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    // One word per AXI read, line base plus beat offset
    assign ar.arvalid = (state == READ_ADDR);
    assign ar.araddr  = {miss_tag, miss_index, word_offset, 2'b00};
    assign rready     = (state == READ_DATA);

    assign ar_done = ar.arvalid && arready;
    assign r_done  = r.rvalid && rready;

    assign data_we    = r_done;
    assign data_waddr = {miss_index, word_offset};
    assign data_wdata = r.rdata;

    // Tag goes valid with the final word so the next lookup hits
    assign tag_we          = r_done && last_beat;
    assign tag_wdata.valid = 1'b1;
    assign tag_wdata.tag   = miss_tag;

    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr)
    );

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        load_use_hazard,
    input  redirect_t   redirect,
    output if_id_t      if_id,
    output logic [31:0] pc,
    output axi_ar_t     ar,
    input  logic        arready,
    input  axi_r_t      r,
    output logic        rready
);

    logic [29:0]                fetch_addr;
    logic [31:0]                fetch_rdata;
    logic                       icache_stall;
    tag_entry_t                 tag_rdata;
    tag_entry_t                 tag_wdata;
    logic                       tag_we;
    logic [31:0]                data_rdata;
    logic [31:0]                data_wdata;
    logic                       data_we;
    logic [`FETCH_DATA_AW-1:0]  data_waddr;
    logic                       refill_start;
    logic                       ar_done;
    logic                       r_done;
    logic [`FETCH_OFFSET_W-1:0] word_offset;
    logic                       last_beat;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .flush           (flush),
        .load_use_hazard (load_use_hazard),
        .redirect        (redirect),
        .icache_stall    (icache_stall),
        .fetch_rdata     (fetch_rdata),
        .fetch_addr      (fetch_addr),
        .if_id           (if_id),
        .pc              (pc)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_addr   (fetch_addr),
        .fetch_rdata  (fetch_rdata),
        .icache_stall (icache_stall),
        .tag_rdata    (tag_rdata),
        .tag_we       (tag_we),
        .tag_wdata    (tag_wdata),
        .data_rdata   (data_rdata),
        .data_we      (data_we),
        .data_waddr   (data_waddr),
        .data_wdata   (data_wdata),
        .ar           (ar),
        .arready      (arready),
        .r            (r),
        .rready       (rready),
        .refill_start (refill_start),
        .ar_done      (ar_done),
        .r_done       (r_done),
        .word_offset  (word_offset),
        .last_beat    (last_beat)
    );

    refill_counter u_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (refill_start),
        .ar_done     (ar_done),
        .r_done      (r_done),
        .word_offset (word_offset),
        .last_beat   (last_beat)
    );

    // Tag array indexed by line
    icache_ram #(
        .entry_t (tag_entry_t),
        .depth   (`FETCH_LINES)
    ) u_tags (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (tag_we),
        .waddr (data_waddr[`FETCH_DATA_AW-1:`FETCH_OFFSET_W]),
        .raddr (fetch_addr[`FETCH_DATA_AW-1:`FETCH_OFFSET_W]),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    // Data array indexed by line and word
    icache_ram #(
        .entry_t (logic [31:0]),
        .depth   (`FETCH_DATA_DEPTH)
    ) u_data (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (data_we),
        .waddr (data_waddr),
        .raddr (fetch_addr[`FETCH_DATA_AW-1:0]),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int RUN_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
    localparam int LINE_BYTES     = 4 * `FETCH_LINE_WORDS;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        load_use_hazard;
    redirect_t   redirect;
    if_id_t      if_id;
    logic [31:0] pc;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;

    int seed;
    int cycles;
    int errors;

    // Reference cache and PC
    logic        m_valid [`FETCH_LINES];
    logic [31:0] m_tag [`FETCH_LINES];
    logic [31:0] exp_pc;
    if_id_t      exp_if_id;
    logic        exp_arvalid;
    logic        exp_rready;
    logic        refilling;
    logic [31:0] miss_line;
    int          ar_issued;
    int          r_beats;
    int          miss_count;
    int          dut_refills;
    int          exp_refills;

    // Memory model state
    int          ar_wait;
    logic        r_pending;
    int          r_wait;
    logic [31:0] r_addr;
    logic        prev_ar_wait;
    logic [31:0] prev_araddr;

    fetch_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .flush           (flush),
        .load_use_hazard (load_use_hazard),
        .redirect        (redirect),
        .if_id           (if_id),
        .pc              (pc),
        .ar              (ar),
        .arready         (arready),
        .r               (r),
        .rready          (rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // Each memory word is a fixed hash of its byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return ((addr ^ 32'h5a5a_c3c3) * 32'h0019_660d) + {addr[7:0], addr[31:8]};
    endfunction

    function automatic logic [31:0] byte_reverse(input logic [31:0] w);
        logic [31:0] o;
        for (int i = 0; i < 4; i++) begin
            o[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return o;
    endfunction

    function automatic logic one_in(input int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return addr / LINE_BYTES;
    endfunction

    function automatic logic model_hit(input logic [31:0] addr);
        logic [31:0] line;
        int          idx;
        line = line_of(addr);
        idx  = int'(line % `FETCH_LINES);
        return m_valid[idx] && (m_tag[idx] == line / `FETCH_LINES);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Check failed: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    // Outputs settle after the rising edge and are compared at the falling edge
    task automatic check_outputs();
        assert (pc === exp_pc) else report_mismatch("pc", pc, exp_pc);
        assert (if_id.pc === exp_if_id.pc)
            else report_mismatch("if_id.pc", if_id.pc, exp_if_id.pc);
        assert (if_id.inst === exp_if_id.inst)
            else report_mismatch("if_id.inst", if_id.inst, exp_if_id.inst);
        assert (ar.arvalid === exp_arvalid)
            else report_mismatch("ar.arvalid", 32'(ar.arvalid), 32'(exp_arvalid));
        if (prev_ar_wait) begin
            assert (ar.araddr === prev_araddr)
                else report_mismatch("ar.araddr", ar.araddr, prev_araddr);
        end
        assert (rready === exp_rready)
            else report_mismatch("rready", 32'(rready), 32'(exp_rready));
    endtask

    task automatic drive_inputs();
        stall           = one_in(10);
        flush           = one_in(10);
        load_use_hazard = one_in(10);
        // Codes 01 and 10 redirect, each in about 5% of cycles
        redirect.pc_src = one_in(5) ? 2'(rand_below(4)) : 2'b00;
        // Targets stay in a 1 KB window so lines get reused
        redirect.pc_branch = `FETCH_RESET_PC + 32'(rand_below(256) * 4);
        redirect.pc_j      = `FETCH_RESET_PC + 32'(rand_below(256) * 4);

        if (ar.arvalid) begin
            if (ar_wait < 0) begin
                ar_wait = rand_below(4);
            end
            arready = (ar_wait == 0);
            if (ar_wait > 0) begin
                ar_wait--;
            end
        end else begin
            arready = 1'b0;
        end

        r.rresp = 2'b00;
        if (r_pending && r_wait == 0) begin
            r.rvalid = 1'b1;
            r.rdata  = mem_word(r_addr);
        end else begin
            r.rvalid = 1'b0;
            r.rdata  = '0;
            if (r_pending) begin
                r_wait--;
            end
        end
    endtask

    // Predicts the coming rising edge
    task automatic step_model();
        logic        m_stall;
        logic        start;
        logic [31:0] cur_pc;
        logic [31:0] ar_exp;
        int          idx;

        cur_pc  = exp_pc;
        m_stall = refilling || !model_hit(cur_pc);
        start   = !refilling && !model_hit(cur_pc);

        exp_if_id.pc   = cur_pc;
        exp_if_id.inst = (flush || m_stall) ? `FETCH_NOP : byte_reverse(mem_word(cur_pc));

        if (!(stall || load_use_hazard || m_stall)) begin
            case (redirect.pc_src)
                2'b01:   exp_pc = redirect.pc_j;
                2'b10:   exp_pc = redirect.pc_branch;
                default: exp_pc = cur_pc + 32'd4;
            endcase
        end

        prev_ar_wait = ar.arvalid && !arready;
        prev_araddr  = ar.araddr;

        if (ar.arvalid && arready) begin
            ar_exp = miss_line * LINE_BYTES + 32'(ar_issued * 4);
            assert (ar_issued < `FETCH_LINE_WORDS)
                else report_failure("more read requests than words in a line");
            assert (ar.araddr === ar_exp) else report_mismatch("ar.araddr", ar.araddr, ar_exp);
            if ((ar.araddr % LINE_BYTES) == 0) begin
                dut_refills++;
            end
            ar_issued++;
            exp_arvalid = 1'b0;
            exp_rready  = 1'b1;
            ar_wait     = -1;
            r_pending   = 1'b1;
            r_wait      = rand_below(4);
            r_addr      = ar.araddr;
        end

        if (rready && r.rvalid) begin
            r_pending  = 1'b0;
            exp_rready = 1'b0;
            r_beats++;
            if (r_beats == `FETCH_LINE_WORDS) begin
                assert (ar_issued == `FETCH_LINE_WORDS)
                    else report_failure("refill ended before all words were requested");
                idx          = int'(miss_line % `FETCH_LINES);
                m_valid[idx] = 1'b1;
                m_tag[idx]   = miss_line / `FETCH_LINES;
                refilling    = 1'b0;
            end else begin
                exp_arvalid = 1'b1;
            end
        end

        if (start) begin
            refilling   = 1'b1;
            miss_line   = line_of(cur_pc);
            ar_issued   = 0;
            r_beats     = 0;
            exp_arvalid = 1'b1;
            miss_count++;
        end
    endtask

    initial begin
        seed            = 32'h97b9_a9ae;
        cycles          = 0;
        errors          = 0;
        rst_n           = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        load_use_hazard = 1'b0;
        redirect        = '0;
        arready         = 1'b0;
        r               = '0;

        for (int i = 0; i < `FETCH_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
        end
        exp_pc       = `FETCH_RESET_PC;
        exp_if_id    = '0;
        exp_arvalid  = 1'b0;
        exp_rready   = 1'b0;
        refilling    = 1'b0;
        miss_line    = '0;
        ar_issued    = 0;
        r_beats      = 0;
        miss_count   = 0;
        dut_refills  = 0;
        ar_wait      = -1;
        r_pending    = 1'b0;
        r_wait       = 0;
        r_addr       = '0;
        prev_ar_wait = 1'b0;
        prev_araddr  = '0;

        repeat (10) @(negedge clk);
        check_outputs();
        rst_n = 1'b1;

        repeat (RUN_CYCLES) begin
            drive_inputs();
            step_model();
            @(negedge clk);
            check_outputs();
        end

        // A refill whose first request is not yet accepted is still pending
        exp_refills = miss_count - ((refilling && ar_issued == 0) ? 1 : 0);
        assert (dut_refills == exp_refills)
            else report_mismatch("refill_count", 32'(dut_refills), 32'(exp_refills));

        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/icache_ram.sv
logic/refill_counter.sv
logic/icache_ctrl.sv
logic/fetch_top.sv
verif/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result line in $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
